//--- logic/linedoubler_pkg.sv
/* Shared widths, line buffer geometry and raster constants of the line doubler.
   NUM_PAGES must be a power of two. The stored window must fit in every input line. */

package linedoubler_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // color widths

  localparam int COLOR_W_I = 7;
  localparam int COLOR_W_O = 8;  // input width plus one replicated bit

  //////////////////////////////////////////////////////////////////////////////
  // line buffer geometry

  localparam int NUM_PAGES = 4;
  localparam int PAGE_W    = $clog2(NUM_PAGES);

  localparam int HSTART_IN  = 16;  // first stored pixel after the hsync fall
  localparam int HSTOP_IN   = 80;  // first pixel past the stored window
  localparam int PAGE_DEPTH = HSTOP_IN - HSTART_IN;
  localparam int ADDR_W     = $clog2(PAGE_DEPTH);

  //////////////////////////////////////////////////////////////////////////////
  // raster

  localparam int PIXEL_PER_LINE_MAX = 1023;  // writer counter saturates here
  localparam int HCNT_W             = $clog2(PIXEL_PER_LINE_MAX + 1);
  localparam int VCNT_W             = 11;    // holds a doubled PAL field

  localparam int HSTART_OUT   = 16;
  localparam int HS_WIDTH_OUT = 8;   // cycles
  localparam int VS_WIDTH_OUT = 6;   // output lines

  // scanline strength and passthrough delay
  localparam int SL_STR_W   = 8;
  localparam int PT_LATENCY = 2;

  // reader states
  localparam logic [1:0] RD_WAIT    = 2'd0;
  localparam logic [1:0] RD_READY   = 2'd1;
  localparam logic [1:0] RD_READING = 2'd2;

endpackage

//--- logic/line_writer.sv
/* Input side. Edges of the syncs count only on valid pixels. A line that overflows
   or ends before HSTOP_IN is marked invalid and sends the page back to zero. */

`timescale 1ns/1ps

module line_writer (
  input  logic                                 VCLK_o,
  input  logic                                 nVRST_o,
  input  logic                                 vdata_valid_i,
  input  logic                                 nvsync_i,
  input  logic                                 nhsync_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] r_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] g_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] b_i,
  output logic                                 wr_en_o,
  output logic [linedoubler_pkg::PAGE_W-1:0]    wr_page_o,
  output logic [linedoubler_pkg::ADDR_W-1:0]    wr_addr_o,
  output logic [linedoubler_pkg::COLOR_W_I-1:0] wr_r_o,
  output logic [linedoubler_pkg::COLOR_W_I-1:0] wr_g_o,
  output logic [linedoubler_pkg::COLOR_W_I-1:0] wr_b_o,
  output logic [linedoubler_pkg::PAGE_W-1:0]    cur_page_o,
  output logic [linedoubler_pkg::HCNT_W-1:0]    line_width_o,
  output logic                                 line_valid_o,
  output logic                                 frame_tgl_o
);

  import linedoubler_pkg::*;

  logic              hs_prev;  // syncs of the previous valid pixel
  logic              vs_prev;
  logic              hs_fall;
  logic              vs_fall;
  logic              in_win;
  logic              line_ok;
  logic [HCNT_W-1:0] hcnt;     // pixels seen since the last hsync fall
  logic [PAGE_W-1:0] page;

  assign hs_fall = vdata_valid_i && hs_prev && !nhsync_i;
  assign vs_fall = vdata_valid_i && vs_prev && !nvsync_i;

  // the fall pixel itself sits at position zero and is never stored
  assign in_win  = !hs_fall && (hcnt >= HCNT_W'(HSTART_IN)) && (hcnt < HCNT_W'(HSTOP_IN));
  assign line_ok = (hcnt >= HCNT_W'(HSTOP_IN)) && (hcnt != HCNT_W'(PIXEL_PER_LINE_MAX));

  assign wr_page_o  = page;  // window never spans a page change
  assign cur_page_o = page;

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      hs_prev      <= 1'b1;
      vs_prev      <= 1'b1;
      hcnt         <= '0;
      page         <= '0;
      wr_en_o      <= 1'b0;
      line_width_o <= '0;
      line_valid_o <= 1'b0;
      frame_tgl_o  <= 1'b0;
    end else begin
      wr_en_o <= 1'b0;
      if (vdata_valid_i) begin
        hs_prev <= nhsync_i;
        vs_prev <= nvsync_i;
        if (vs_fall)
          frame_tgl_o <= ~frame_tgl_o;  // field start

        if (hs_fall) begin
          hcnt         <= HCNT_W'(1);
          line_width_o <= hcnt;
          line_valid_o <= line_ok;
          if (!line_ok)
            page <= '0;
          else
            page <= page + 1'b1;  // wraps, NUM_PAGES is a power of two
        end else if (hcnt != HCNT_W'(PIXEL_PER_LINE_MAX)) begin
          hcnt <= hcnt + 1'b1;
        end

        if (in_win)
          wr_en_o <= 1'b1;
      end
    end
  end

  // pixel data and address, qualified by wr_en_o
  always_ff @(posedge VCLK_o) begin
    if (vdata_valid_i) begin
      wr_addr_o <= ADDR_W'(hcnt - HCNT_W'(HSTART_IN));
      wr_r_o    <= r_i;
      wr_g_o    <= g_i;
      wr_b_o    <= b_i;
    end
  end

endmodule

//--- logic/line_buffer.sv
/* Four page line store, one write and one read port on the same clock.
   Read data shows up one cycle after rd_en_i and holds while rd_en_i is low. */

`timescale 1ns/1ps

module line_buffer (
  input  logic                                 VCLK_o,
  input  logic                                 wr_en_i,
  input  logic [linedoubler_pkg::PAGE_W-1:0]    wr_page_i,
  input  logic [linedoubler_pkg::ADDR_W-1:0]    wr_addr_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] wr_r_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] wr_g_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] wr_b_i,
  input  logic                                 rd_en_i,
  input  logic [linedoubler_pkg::PAGE_W-1:0]    rd_page_i,
  input  logic [linedoubler_pkg::ADDR_W-1:0]    rd_addr_i,
  output logic [linedoubler_pkg::COLOR_W_I-1:0] rd_r_o,
  output logic [linedoubler_pkg::COLOR_W_I-1:0] rd_g_o,
  output logic [linedoubler_pkg::COLOR_W_I-1:0] rd_b_o
);

  import linedoubler_pkg::*;

  logic [3*COLOR_W_I-1:0] mem [NUM_PAGES][PAGE_DEPTH];
  logic [3*COLOR_W_I-1:0] rd_word;

  always_ff @(posedge VCLK_o) begin
    if (wr_en_i)
      mem[wr_page_i][wr_addr_i] <= {wr_r_i, wr_g_i, wr_b_i};
    if (rd_en_i)
      rd_word <= mem[rd_page_i][rd_addr_i];  // registered read for block RAM
  end

  assign {rd_r_o, rd_g_o, rd_b_o} = rd_word;

endmodule

//--- logic/line_reader.sv
/* Output raster. Each page is replayed twice, reading two pages behind the writer.
   Reading starts on the second field start and stops on an invalid line. */

`timescale 1ns/1ps

module line_reader (
  input  logic                              VCLK_o,
  input  logic                              nVRST_o,
  input  logic                              dbl_en_i,
  input  logic                              sl_en_i,
  input  logic                              sl_id_i,
  input  logic [linedoubler_pkg::PAGE_W-1:0] cur_page_i,
  input  logic [linedoubler_pkg::HCNT_W-1:0] line_width_i,
  input  logic                              line_valid_i,
  input  logic                              frame_tgl_i,
  output logic                              rd_en_o,
  output logic [linedoubler_pkg::PAGE_W-1:0] rd_page_o,
  output logic [linedoubler_pkg::ADDR_W-1:0] rd_addr_o,
  output logic                              pix_en_o,
  output logic                              draw_sl_o,
  output logic                              nhsync_o,
  output logic                              nvsync_o,
  output logic                              dbl_valid_o
);

  import linedoubler_pkg::*;

  logic [1:0]        state;
  logic              tgl_prev;
  logic              frame_pend;  // field started, vsync goes with the next line
  logic [PAGE_W-1:0] page_prev;
  logic [PAGE_W-1:0] rd_page;
  logic [PAGE_W-1:0] start_page;
  logic [HCNT_W-1:0] width_mem [NUM_PAGES];
  logic [HCNT_W-1:0] hcnt;
  logic              rep;         // which copy of the line
  logic [VCNT_W-1:0] vcnt;
  logic              tgl_evt;
  logic              reading;
  logic              line_end;

  assign tgl_evt  = frame_tgl_i ^ tgl_prev;
  assign reading  = (state == RD_READING);
  assign line_end = (hcnt == width_mem[rd_page] - 1'b1);

  // two pages behind the writer, modulo the page count
  assign start_page = cur_page_i - PAGE_W'(2);

  // width of each completed page, taken when the writer moves on
  always_ff @(posedge VCLK_o) begin
    if (cur_page_i != page_prev)
      width_mem[page_prev] <= line_width_i;
  end

  //////////////////////////////////////////////////////////////////////////////
  // read FSM and output counters

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      state      <= RD_WAIT;
      tgl_prev   <= 1'b0;
      frame_pend <= 1'b0;
      page_prev  <= '0;
      rd_page    <= '0;
      hcnt       <= '0;
      rep        <= 1'b0;
      vcnt       <= '0;
    end else begin
      tgl_prev  <= frame_tgl_i;
      page_prev <= cur_page_i;

      case (state)
        RD_WAIT:
          if (tgl_evt)
            state <= RD_READY;  // first field lets the widths settle
        RD_READY:
          if (tgl_evt) begin
            state      <= RD_READING;
            rd_page    <= start_page;
            hcnt       <= '0;
            rep        <= 1'b0;
            vcnt       <= '0;  // begins with vsync
            frame_pend <= 1'b0;
          end
        RD_READING:
          if (line_end) begin
            hcnt <= '0;
            rep  <= ~rep;
            if (rep)
              rd_page <= rd_page + 1'b1;  // wraps with the page count
            if (frame_pend || tgl_evt) begin
              vcnt       <= '0;
              frame_pend <= 1'b0;
            end else if (vcnt != '1) begin
              vcnt <= vcnt + 1'b1;  // saturates if the field never ends
            end
          end else begin
            hcnt <= hcnt + 1'b1;
            if (tgl_evt)
              frame_pend <= 1'b1;
          end
        default:
          state <= RD_WAIT;
      endcase

      if (!dbl_en_i || !line_valid_i)
        state <= RD_WAIT;  // give up and resync
    end
  end

  assign rd_en_o   = reading && (hcnt >= HCNT_W'(HSTART_OUT)) &&
                     (hcnt < HCNT_W'(HSTART_OUT + PAGE_DEPTH));
  assign rd_addr_o = ADDR_W'(hcnt - HCNT_W'(HSTART_OUT));
  assign rd_page_o = rd_page;

  //////////////////////////////////////////////////////////////////////////////
  // one stage to meet the RAM read data

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      pix_en_o    <= 1'b0;
      draw_sl_o   <= 1'b0;
      nhsync_o    <= 1'b1;
      nvsync_o    <= 1'b1;
      dbl_valid_o <= 1'b0;
    end else begin
      pix_en_o    <= rd_en_o;
      draw_sl_o   <= sl_en_i && (rep == sl_id_i);
      nhsync_o    <= !(reading && (hcnt < HCNT_W'(HS_WIDTH_OUT)));
      nvsync_o    <= !(reading && (vcnt < VCNT_W'(VS_WIDTH_OUT)));
      dbl_valid_o <= reading;
    end
  end

endmodule

//--- logic/scanline_dimmer.sv
/* Output stage. Colors widen by repeating their top bit, scanline copies scale by
   256 minus the strength. Passthrough takes the input PT_LATENCY cycles late. */

`timescale 1ns/1ps

module scanline_dimmer (
  input  logic                                 VCLK_o,
  input  logic                                 nVRST_o,
  input  logic                                 dbl_en_i,
  input  logic [linedoubler_pkg::SL_STR_W-1:0]  sl_str_i,
  input  logic                                 vdata_valid_i,
  input  logic                                 nvsync_i,
  input  logic                                 nhsync_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] r_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] g_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] b_i,
  input  logic                                 pix_en_i,
  input  logic                                 draw_sl_i,
  input  logic                                 dbl_nhsync_i,
  input  logic                                 dbl_nvsync_i,
  input  logic                                 dbl_valid_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] rd_r_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] rd_g_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] rd_b_i,
  output logic                                 vdata_valid_o,
  output logic                                 nvsync_o,
  output logic                                 nhsync_o,
  output logic [linedoubler_pkg::COLOR_W_O-1:0] r_o,
  output logic [linedoubler_pkg::COLOR_W_O-1:0] g_o,
  output logic [linedoubler_pkg::COLOR_W_O-1:0] b_o
);

  import linedoubler_pkg::*;

  logic [PT_LATENCY-2:0][3*COLOR_W_I+2:0] pt_dly;  // {valid, vs, hs, r, g, b}
  logic                                   pt_valid;
  logic                                   pt_nvsync;
  logic                                   pt_nhsync;
  logic [COLOR_W_I-1:0]                   pt_r;
  logic [COLOR_W_I-1:0]                   pt_g;
  logic [COLOR_W_I-1:0]                   pt_b;
  logic [SL_STR_W:0]                      sl_gain;

  function automatic logic [COLOR_W_O-1:0] widen(input logic [COLOR_W_I-1:0] c);
    return {c, c[COLOR_W_I-1]};
  endfunction

  // doubled path color: blank, plain or darkened
  function automatic logic [COLOR_W_O-1:0] shade(input logic [COLOR_W_I-1:0] c,
                                                 input logic en,
                                                 input logic sl,
                                                 input logic [SL_STR_W:0] gain);
    logic [COLOR_W_O+SL_STR_W:0] prod;
    prod = widen(c) * gain;
    if (!en)
      return '0;
    return sl ? prod[COLOR_W_O+SL_STR_W-1:SL_STR_W] : widen(c);
  endfunction

  assign sl_gain = {1'b1, {SL_STR_W{1'b0}}} - {1'b0, sl_str_i};  // 256 - strength

  assign {pt_valid, pt_nvsync, pt_nhsync, pt_r, pt_g, pt_b} = pt_dly[PT_LATENCY-2];

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      for (int i = 0; i < PT_LATENCY - 1; i++)
        pt_dly[i] <= {1'b0, 2'b11, {3*COLOR_W_I{1'b0}}};  // idle: syncs high
      vdata_valid_o <= 1'b0;
      nvsync_o      <= 1'b1;
      nhsync_o      <= 1'b1;
      r_o           <= '0;
      g_o           <= '0;
      b_o           <= '0;
    end else begin
      pt_dly[0] <= {vdata_valid_i, nvsync_i, nhsync_i, r_i, g_i, b_i};
      for (int i = 1; i < PT_LATENCY - 1; i++)
        pt_dly[i] <= pt_dly[i-1];

      if (dbl_en_i) begin
        vdata_valid_o <= dbl_valid_i;
        nvsync_o      <= dbl_nvsync_i;
        nhsync_o      <= dbl_nhsync_i;
        r_o           <= shade(rd_r_i, pix_en_i, draw_sl_i, sl_gain);
        g_o           <= shade(rd_g_i, pix_en_i, draw_sl_i, sl_gain);
        b_o           <= shade(rd_b_i, pix_en_i, draw_sl_i, sl_gain);
      end else begin  // passthrough
        vdata_valid_o <= pt_valid;
        nvsync_o      <= pt_nvsync;
        nhsync_o      <= pt_nhsync;
        r_o           <= widen(pt_r);
        g_o           <= widen(pt_g);
        b_o           <= widen(pt_b);
      end
    end
  end

endmodule

//--- logic/linedoubler_top.sv
/* Line doubler top level. All blocks run on VCLK_o, the input rate comes
   from vdata_valid_i, at most one pixel every second cycle. */

`timescale 1ns/1ps

module linedoubler_top (
  input  logic                                 VCLK_o,
  input  logic                                 nVRST_o,
  input  logic                                 vdata_valid_i,
  input  logic                                 nvsync_i,
  input  logic                                 nhsync_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] r_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] g_i,
  input  logic [linedoubler_pkg::COLOR_W_I-1:0] b_i,
  input  logic                                 dbl_en_i,
  input  logic                                 sl_en_i,
  input  logic                                 sl_id_i,
  input  logic [linedoubler_pkg::SL_STR_W-1:0]  sl_str_i,
  output logic                                 vdata_valid_o,
  output logic                                 nvsync_o,
  output logic                                 nhsync_o,
  output logic [linedoubler_pkg::COLOR_W_O-1:0] r_o,
  output logic [linedoubler_pkg::COLOR_W_O-1:0] g_o,
  output logic [linedoubler_pkg::COLOR_W_O-1:0] b_o
);

  import linedoubler_pkg::*;

  // writer side
  logic                 wr_en;
  logic [PAGE_W-1:0]    wr_page;
  logic [ADDR_W-1:0]    wr_addr;
  logic [COLOR_W_I-1:0] wr_r;
  logic [COLOR_W_I-1:0] wr_g;
  logic [COLOR_W_I-1:0] wr_b;
  logic [PAGE_W-1:0]    cur_page;
  logic [HCNT_W-1:0]    line_width;
  logic                 line_valid;
  logic                 frame_tgl;

  // reader side
  logic                 rd_en;
  logic [PAGE_W-1:0]    rd_page;
  logic [ADDR_W-1:0]    rd_addr;
  logic [COLOR_W_I-1:0] rd_r;
  logic [COLOR_W_I-1:0] rd_g;
  logic [COLOR_W_I-1:0] rd_b;
  logic                 pix_en;
  logic                 draw_sl;
  logic                 dbl_nhsync;
  logic                 dbl_nvsync;
  logic                 dbl_valid;

  line_writer i_line_writer (
    .VCLK_o, .nVRST_o, .vdata_valid_i, .nvsync_i, .nhsync_i, .r_i, .g_i, .b_i,
    .wr_en_o      (wr_en),
    .wr_page_o    (wr_page),
    .wr_addr_o    (wr_addr),
    .wr_r_o       (wr_r),
    .wr_g_o       (wr_g),
    .wr_b_o       (wr_b),
    .cur_page_o   (cur_page),
    .line_width_o (line_width),
    .line_valid_o (line_valid),
    .frame_tgl_o  (frame_tgl)
  );

  line_buffer i_line_buffer (
    .VCLK_o,
    .wr_en_i   (wr_en),
    .wr_page_i (wr_page),
    .wr_addr_i (wr_addr),
    .wr_r_i    (wr_r),
    .wr_g_i    (wr_g),
    .wr_b_i    (wr_b),
    .rd_en_i   (rd_en),
    .rd_page_i (rd_page),
    .rd_addr_i (rd_addr),
    .rd_r_o    (rd_r),
    .rd_g_o    (rd_g),
    .rd_b_o    (rd_b)
  );

  line_reader i_line_reader (
    .VCLK_o, .nVRST_o, .dbl_en_i, .sl_en_i, .sl_id_i,
    .cur_page_i   (cur_page),
    .line_width_i (line_width),
    .line_valid_i (line_valid),
    .frame_tgl_i  (frame_tgl),
    .rd_en_o      (rd_en),
    .rd_page_o    (rd_page),
    .rd_addr_o    (rd_addr),
    .pix_en_o     (pix_en),
    .draw_sl_o    (draw_sl),
    .nhsync_o     (dbl_nhsync),
    .nvsync_o     (dbl_nvsync),
    .dbl_valid_o  (dbl_valid)
  );

  scanline_dimmer i_scanline_dimmer (
    .VCLK_o, .nVRST_o, .dbl_en_i, .sl_str_i,
    .vdata_valid_i, .nvsync_i, .nhsync_i, .r_i, .g_i, .b_i,
    .pix_en_i     (pix_en),
    .draw_sl_i    (draw_sl),
    .dbl_nhsync_i (dbl_nhsync),
    .dbl_nvsync_i (dbl_nvsync),
    .dbl_valid_i  (dbl_valid),
    .rd_r_i       (rd_r),
    .rd_g_i       (rd_g),
    .rd_b_i       (rd_b),
    .vdata_valid_o, .nvsync_o, .nhsync_o, .r_o, .g_o, .b_o
  );

endmodule

//--- sim/tb_clock_gen.sv
/* Testbench clock, 20 ns period. Reset is held low for 16 cycles
   and released on a falling edge. */

`timescale 1ns/1ps

module tb_clock_gen (
  output logic VCLK_o,
  output logic nVRST_o
);

  localparam time HALF_PERIOD = 10ns;

  initial begin
    VCLK_o = 1'b0;
    forever #HALF_PERIOD VCLK_o = ~VCLK_o;
  end

  initial begin
    nVRST_o = 1'b0;
    repeat (16) @(posedge VCLK_o);
    @(negedge VCLK_o);
    nVRST_o = 1'b1;  // release away from the active edge
  end

endmodule

//--- sim/tb_linedoubler.sv
/* Directed tests of the line doubler. Input lines are 96 pixels on every second cycle,
   20 lines per field, window colors random and nonzero. Stops at the first error. */

`timescale 1ns/1ps

module tb_linedoubler;

  import linedoubler_pkg::*;

  localparam int LINE_PIX    = 96;  // input pixels per line
  localparam int HS_IN_PIX   = 8;
  localparam int FIELD_LINES = 20;
  localparam int VS_IN_LINES = 3;
  localparam int FIELD_CYC   = 2 * LINE_PIX * FIELD_LINES;

  logic                 VCLK_o;
  logic                 nVRST_o;
  logic                 vdata_valid_i;
  logic                 nvsync_i;
  logic                 nhsync_i;
  logic [COLOR_W_I-1:0] r_i;
  logic [COLOR_W_I-1:0] g_i;
  logic [COLOR_W_I-1:0] b_i;
  logic                 dbl_en_i;
  logic                 sl_en_i;
  logic                 sl_id_i;
  logic [SL_STR_W-1:0]  sl_str_i;
  logic                 vdata_valid_o;
  logic                 nvsync_o;
  logic                 nhsync_o;
  logic [COLOR_W_O-1:0] r_o;
  logic [COLOR_W_O-1:0] g_o;
  logic [COLOR_W_O-1:0] b_o;

  int                     err_cnt = 0;
  logic                   pt_chk  = 1'b0;
  logic [3*COLOR_W_I+2:0] hist1;          // {valid, vs, hs, r, g, b} one cycle back
  logic [3*COLOR_W_I+2:0] hist2;          // and two cycles back
  logic                   cap_en  = 1'b0;
  logic                   prev_hs = 1'b1;
  logic                   mon_open = 1'b0;
  int                     mon_cycles;
  int                     mon_hs_low;
  logic                   mon_vs;
  logic [3*COLOR_W_O-1:0] mon_pix [$];    // nonzero pixels of the open line
  logic [3*COLOR_W_O-1:0] out_q [$];      // PAGE_DEPTH pixels per finished line
  logic                   vs_q [$];       // nvsync_o of each finished line
  logic [3*COLOR_W_I-1:0] in_q [$];       // input windows in order

  tb_clock_gen clk_gen (.VCLK_o(VCLK_o), .nVRST_o(nVRST_o));

  linedoubler_top i_linedoubler_top (
    .VCLK_o(VCLK_o), .nVRST_o(nVRST_o),
    .vdata_valid_i(vdata_valid_i), .nvsync_i(nvsync_i), .nhsync_i(nhsync_i),
    .r_i(r_i), .g_i(g_i), .b_i(b_i),
    .dbl_en_i(dbl_en_i), .sl_en_i(sl_en_i), .sl_id_i(sl_id_i), .sl_str_i(sl_str_i),
    .vdata_valid_o(vdata_valid_o), .nvsync_o(nvsync_o), .nhsync_o(nhsync_o),
    .r_o(r_o), .g_o(g_o), .b_o(b_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // error handling and compares

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_color(input string name, input logic [COLOR_W_O-1:0] got,
                               input logic [COLOR_W_O-1:0] exp);
    if (got !== exp) begin
      err_cnt++;
      abort_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic compare_sync(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_cnt++;
      abort_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      err_cnt++;
      abort_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // expected values from the conversion rules
  function automatic logic [COLOR_W_O-1:0] widen_color(input logic [COLOR_W_I-1:0] c);
    return (COLOR_W_O'(c) << 1) | COLOR_W_O'(c[COLOR_W_I-1]);
  endfunction

  function automatic logic [COLOR_W_O-1:0] dim_color(input logic [COLOR_W_O-1:0] c,
                                                     input logic [SL_STR_W-1:0] s);
    int prod;
    prod = int'(c) * (256 - int'(s));
    return COLOR_W_O'(prod >> 8);
  endfunction

  function automatic logic [3*COLOR_W_O-1:0] widen_pixel(input logic [3*COLOR_W_I-1:0] p);
    return {widen_color(p[3*COLOR_W_I-1:2*COLOR_W_I]),
            widen_color(p[2*COLOR_W_I-1:COLOR_W_I]), widen_color(p[COLOR_W_I-1:0])};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  task automatic drive_cycle(input logic valid, input logic vs, input logic hs,
                             input logic [COLOR_W_I-1:0] r, input logic [COLOR_W_I-1:0] g,
                             input logic [COLOR_W_I-1:0] b);
    @(negedge VCLK_o);
    if (pt_chk) begin  // passthrough shows the input of two cycles ago
      compare_sync("vdata_valid_o", vdata_valid_o, hist2[3*COLOR_W_I+2]);
      compare_sync("nvsync_o", nvsync_o, hist2[3*COLOR_W_I+1]);
      compare_sync("nhsync_o", nhsync_o, hist2[3*COLOR_W_I]);
      compare_color("r_o", r_o, widen_color(hist2[3*COLOR_W_I-1:2*COLOR_W_I]));
      compare_color("g_o", g_o, widen_color(hist2[2*COLOR_W_I-1:COLOR_W_I]));
      compare_color("b_o", b_o, widen_color(hist2[COLOR_W_I-1:0]));
    end
    vdata_valid_i = valid;
    nvsync_i      = vs;
    nhsync_i      = hs;
    r_i           = r;
    g_i           = g;
    b_i           = b;
    hist2 = hist1;
    hist1 = {valid, vs, hs, r, g, b};
  endtask

  task automatic drive_idle(input int n);
    repeat (n) drive_cycle(1'b0, 1'b1, 1'b1, '0, '0, '0);
  endtask

  task automatic drive_line(input logic vs);
    logic [COLOR_W_I-1:0] r;
    logic [COLOR_W_I-1:0] g;
    logic [COLOR_W_I-1:0] b;
    for (int k = 0; k < LINE_PIX; k++) begin
      r = COLOR_W_I'($urandom_range(127, 1));  // never zero
      g = COLOR_W_I'($urandom_range(127, 1));
      b = COLOR_W_I'($urandom_range(127, 1));
      if (k >= HSTART_IN && k < HSTOP_IN)
        in_q.push_back({r, g, b});
      drive_cycle(1'b1, vs, k >= HS_IN_PIX, r, g, b);
      drive_cycle(1'b0, vs, k >= HS_IN_PIX, r, g, b);  // gap cycle
    end
  endtask

  task automatic drive_field();
    for (int l = 0; l < FIELD_LINES; l++)
      drive_line(l >= VS_IN_LINES);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output line monitor, from one nhsync_o fall to the next

  task automatic commit_line();
    compare_count("output line length", mon_cycles, LINE_PIX);
    compare_count("nhsync_o low cycles", mon_hs_low, HS_WIDTH_OUT);
    compare_count("window pixels per line", mon_pix.size(), PAGE_DEPTH);
    foreach (mon_pix[i])
      out_q.push_back(mon_pix[i]);
    vs_q.push_back(mon_vs);
  endtask

  always @(negedge VCLK_o) begin
    logic [3*COLOR_W_O-1:0] pix;
    pix = {r_o, g_o, b_o};
    if (!cap_en) begin
      mon_open = 1'b0;
    end else if (prev_hs && !nhsync_o) begin
      if (mon_open)
        commit_line();
      compare_sync("vdata_valid_o", vdata_valid_o, 1'b1);
      mon_open   = 1'b1;
      mon_cycles = 1;
      mon_hs_low = 1;
      mon_vs     = nvsync_o;
      mon_pix.delete();
      if (pix != '0)
        mon_pix.push_back(pix);
    end else if (mon_open) begin
      mon_cycles++;
      if (!nhsync_o)
        mon_hs_low++;
      compare_sync("vdata_valid_o", vdata_valid_o, 1'b1);  // high all through reading
      compare_sync("nvsync_o within line", nvsync_o, mon_vs);
      if (pix != '0)
        mon_pix.push_back(pix);
    end
    prev_hs = nhsync_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests

  task automatic check_idle_outputs();
    compare_sync("vdata_valid_o", vdata_valid_o, 1'b0);
    compare_sync("nvsync_o", nvsync_o, 1'b1);
    compare_sync("nhsync_o", nhsync_o, 1'b1);
    compare_color("r_o", r_o, '0);
    compare_color("g_o", g_o, '0);
    compare_color("b_o", b_o, '0);
  endtask

  task automatic check_reset();
    int waited;
    waited = 0;
    while (nVRST_o !== 1'b1) begin
      @(negedge VCLK_o);
      check_idle_outputs();
      waited++;
      if (waited > 40)
        abort_run("reset was never released");
    end
    repeat (3) begin
      @(negedge VCLK_o);
      check_idle_outputs();
    end
  endtask

  task automatic run_passthrough();
    drive_idle(2);
    pt_chk = 1'b1;
    drive_field();
    drive_idle(4);
    pt_chk = 1'b0;
  endtask

  function automatic bit window_matches(input int win, input int line);
    for (int k = 0; k < PAGE_DEPTH; k++)
      if (widen_pixel(in_q[win*PAGE_DEPTH+k]) !== out_q[line*PAGE_DEPTH+k])
        return 1'b0;
    return 1'b1;
  endfunction

  task automatic check_capture(input logic sl_on, input logic sl_sel,
                               input logic [SL_STR_W-1:0] str);
    int                     n_pairs;
    int                     n_win;
    int                     base;
    int                     run;
    int                     n_runs;
    logic                   dimmed;
    logic [3*COLOR_W_O-1:0] exp;
    logic [3*COLOR_W_O-1:0] got;
    n_pairs = vs_q.size() / 2;
    n_win   = in_q.size() / PAGE_DEPTH;
    if (n_pairs < 4)
      abort_run("too few doubled output lines were captured");
    base = -1;
    for (int j = 0; j < n_win && base < 0; j++)
      if (window_matches(j, (sl_on && !sl_sel) ? 1 : 0))
        base = j;
    if (base < 0)
      abort_run("first output line pair matches no input line");
    for (int p = 0; p < n_pairs; p++) begin
      if (base + p >= n_win)
        abort_run("output lines run past the input lines");
      for (int c = 0; c < 2; c++) begin
        dimmed = sl_on && (c == int'(sl_sel));  // copy c of the pair
        for (int k = 0; k < PAGE_DEPTH; k++) begin
          exp = widen_pixel(in_q[(base+p)*PAGE_DEPTH+k]);
          if (dimmed)
            exp = {dim_color(exp[23:16], str), dim_color(exp[15:8], str),
                   dim_color(exp[7:0], str)};
          got = out_q[(2*p+c)*PAGE_DEPTH+k];
          compare_color("r_o", got[23:16], exp[23:16]);
          compare_color("g_o", got[15:8], exp[15:8]);
          compare_color("b_o", got[7:0], exp[7:0]);
        end
      end
    end
    // vsync pulses that ended inside the capture
    run    = 0;
    n_runs = 0;
    foreach (vs_q[i]) begin
      if (!vs_q[i]) begin
        run++;
      end else begin
        if (run > 0) begin
          compare_count("nvsync_o low lines", run, VS_WIDTH_OUT);
          n_runs++;
        end
        run = 0;
      end
    end
    if (n_runs == 0)
      abort_run("no complete output vsync pulse was seen");
  endtask

  task automatic run_doubling(input logic sl_on, input logic sl_sel,
                              input logic [SL_STR_W-1:0] str);
    int waited;
    in_q.delete();
    out_q.delete();
    vs_q.delete();
    drive_idle(2);
    sl_en_i  = sl_on;
    sl_id_i  = sl_sel;
    sl_str_i = str;
    dbl_en_i = 1'b1;
    fork
      repeat (4) drive_field();
      begin
        waited = 0;
        repeat (2) @(negedge VCLK_o);
        cap_en <= 1'b1;
        while (vdata_valid_o !== 1'b1) begin
          @(negedge VCLK_o);
          waited++;
          if (waited > 3 * FIELD_CYC)
            abort_run("doubled output never started");
        end
      end
    join
    cap_en <= 1'b0;  // drop any partly seen line
    drive_idle(4);
    dbl_en_i = 1'b0;
    sl_en_i  = 1'b0;
    drive_idle(4);
    check_capture(sl_on, sl_sel, str);
  endtask

  initial begin
    void'($urandom(32'hbbc8));
    vdata_valid_i = 1'b0;
    nvsync_i      = 1'b1;
    nhsync_i      = 1'b1;
    r_i           = '0;
    g_i           = '0;
    b_i           = '0;
    dbl_en_i      = 1'b0;
    sl_en_i       = 1'b0;
    sl_id_i       = 1'b0;
    sl_str_i      = '0;
    hist1         = {1'b0, 2'b11, {3*COLOR_W_I{1'b0}}};
    hist2         = hist1;

    check_reset();
    run_passthrough();
    run_doubling(1'b0, 1'b0, 8'h00);
    run_doubling(1'b1, 1'b0, 8'h80);  // first copy dimmed
    run_doubling(1'b1, 1'b1, 8'h40);  // second copy dimmed

    if (err_cnt == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      abort_run("errors were counted during the run");
    end
  end

endmodule

//--- linedoubler.f
logic/linedoubler_pkg.sv
logic/line_writer.sv
logic/line_buffer.sv
logic/line_reader.sv
logic/scanline_dimmer.sv
logic/linedoubler_top.sv
sim/tb_clock_gen.sv
sim/tb_linedoubler.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the line doubler testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  -f linedoubler.f \
  --top-module tb_linedoubler \
  -o tb_linedoubler

# the log decides, not the exit code of the run
./obj_dir/tb_linedoubler | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
  echo "run_sim: test passed"
else
  echo "run_sim: test failed"
  exit 1
fi
